// ==== src.f ====
source/mem_stage_pkg.sv
source/amo_alu.sv
source/mem_op_decode.sv
source/mem_access_seq.sv
source/mem_result.sv
source/mem_stage.sv
dv/dbus_model.sv
dv/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mem_stage_tb -f src.f -o mem_stage_sim
out=$(./obj_dir/mem_stage_sim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// ==== dv/mem_stage_tb.sv ====
// Table-driven testbench for the memory stage with a random-delay data memory.
`timescale 1ns/100ps

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int num_tests  = 34;
    localparam int wait_limit = 40;

    localparam logic [2:0] kd_ld  = 3'd0;
    localparam logic [2:0] kd_st  = 3'd1;
    localparam logic [2:0] kd_amo = 3'd2;
    localparam logic [2:0] kd_alu = 3'd3;
    localparam logic [2:0] kd_trp = 3'd4;

    typedef struct {
        string       name;
        logic [2:0]  kind;
        logic [4:0]  funct;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] init;
        logic        exp_trap;
        logic [3:0]  exp_cause;
        logic [31:0] exp_rd;
        logic [31:0] exp_mem;
    } test_entry_t;

    // Name, kind, funct3 or funct5, rs1, rs2, memory before, trap, cause, rd, memory after.
    test_entry_t tbl [num_tests] = '{
        '{"lb_0",     kd_ld,  0,    'h100, 0, 'h36759483, 0, 0, 'hffffff83, 'h36759483},
        '{"lb_1",     kd_ld,  0,    'h101, 0, 'h36759483, 0, 0, 'hffffff94, 'h36759483},
        '{"lb_2",     kd_ld,  0,    'h102, 0, 'h36759483, 0, 0, 'h00000075, 'h36759483},
        '{"lb_3",     kd_ld,  0,    'h103, 0, 'h36759483, 0, 0, 'h00000036, 'h36759483},
        '{"lbu_1",    kd_ld,  4,    'h101, 0, 'h36759483, 0, 0, 'h00000094, 'h36759483},
        '{"lbu_3",    kd_ld,  4,    'h103, 0, 'h36759483, 0, 0, 'h00000036, 'h36759483},
        '{"lh_0",     kd_ld,  1,    'h100, 0, 'h36759483, 0, 0, 'hffff9483, 'h36759483},
        '{"lh_2",     kd_ld,  1,    'h102, 0, 'h36759483, 0, 0, 'h00003675, 'h36759483},
        '{"lhu_0",    kd_ld,  5,    'h100, 0, 'h36759483, 0, 0, 'h00009483, 'h36759483},
        '{"lw",       kd_ld,  2,    'h104, 0, 'h36759483, 0, 0, 'h36759483, 'h36759483},
        '{"sb_0",     kd_st,  0,    'h108, 'hcafebab5, 'h36759483, 0, 0, 0, 'h367594b5},
        '{"sb_1",     kd_st,  0,    'h109, 'hcafebab5, 'h36759483, 0, 0, 0, 'h3675b583},
        '{"sb_2",     kd_st,  0,    'h10a, 'hcafebab5, 'h36759483, 0, 0, 0, 'h36b59483},
        '{"sb_3",     kd_st,  0,    'h10b, 'hcafebab5, 'h36759483, 0, 0, 0, 'hb5759483},
        '{"sh_0",     kd_st,  1,    'h10c, 'hcafebab5, 'h36759483, 0, 0, 0, 'h3675bab5},
        '{"sh_2",     kd_st,  1,    'h10e, 'hcafebab5, 'h36759483, 0, 0, 0, 'hbab59483},
        '{"sw",       kd_st,  2,    'h110, 'hcafebab5, 'h36759483, 0, 0, 0, 'hcafebab5},
        '{"lh_mis",   kd_ld,  1,    'h101, 0, 'h36759483, 1, 4, 0, 'h36759483},
        '{"lw_mis",   kd_ld,  2,    'h102, 0, 'h36759483, 1, 4, 0, 'h36759483},
        '{"sh_mis",   kd_st,  1,    'h105, 'hcafebab5, 'h36759483, 1, 6, 0, 'h36759483},
        '{"sw_mis",   kd_st,  2,    'h106, 'hcafebab5, 'h36759483, 1, 6, 0, 'h36759483},
        '{"amo_mis",  kd_amo, 'h00, 'h112, 'hf0000001, 'h36759483, 1, 6, 0, 'h36759483},
        '{"ld_bad",   kd_ld,  3,    'h100, 0, 'h36759483, 1, 2, 0, 'h36759483},
        '{"amoadd",   kd_amo, 'h00, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'h26759484},
        '{"amoswap",  kd_amo, 'h01, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'hf0000001},
        '{"amoxor",   kd_amo, 'h04, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'hc6759482},
        '{"amoor",    kd_amo, 'h08, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'hf6759483},
        '{"amoand",   kd_amo, 'h0c, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'h30000001},
        '{"amomin",   kd_amo, 'h10, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'hf0000001},
        '{"amomax",   kd_amo, 'h14, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'h36759483},
        '{"amominu",  kd_amo, 'h18, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'h36759483},
        '{"amomaxu",  kd_amo, 'h1c, 'h114, 'hf0000001, 'h36759483, 0, 0, 'h36759483, 'hf0000001},
        '{"alu",      kd_alu, 0, 'h12345678, 0, 'h36759483, 0, 0, 'h12345678, 'h36759483},
        '{"up_trap",  kd_trp, 0,    'h200, 0, 'h36759483, 1, 'hc, 0, 'h36759483}
    };

    logic        clk;
    logic        rst;
    mem_req_t    req;
    dbus_req_t   dbus_req;
    dbus_resp_t  dbus_resp;
    mem_result_t result;
    logic        stall;
    logic        preload_en;
    logic [29:0] probe_addr;
    logic [31:0] preload_data;
    logic [31:0] peek_data;

    mem_stage #(
        .has_amo (1'b1)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .dbus_resp (dbus_resp),
        .dbus_req  (dbus_req),
        .result    (result),
        .stall     (stall)
    );

    dbus_model u_mem (
        .clk          (clk),
        .rst          (rst),
        .dbus_req     (dbus_req),
        .dbus_resp    (dbus_resp),
        .preload_en   (preload_en),
        .probe_addr   (probe_addr),
        .preload_data (preload_data),
        .peek_data    (peek_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // RV32 encodings with rs1 = x10, rs2 = x11, rd = x5.
    function automatic logic [31:0] make_insn(input logic [2:0] kind, input logic [4:0] funct);
        logic [31:0] word;
        case (kind)
            kd_ld:   word = {12'h000, 5'd10, funct[2:0], 5'd5, 7'b0000011};
            kd_st:   word = {7'h00, 5'd11, 5'd10, funct[2:0], 5'd0, 7'b0100011};
            kd_amo:  word = {funct, 2'b00, 5'd11, 5'd10, 3'b010, 5'd5, 7'b0101111};
            default: word = {7'h00, 5'd11, 5'd10, 3'b000, 5'd5, 7'b0110011};
        endcase
        return word;
    endfunction

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        stop_on_error();
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s %s expected %h actual %h", name, what, exp, got);
            stop_on_error();
        end
    endtask

    // Ends on a falling edge where stall is low, so the next rising edge accepts.
    task automatic wait_stall_low(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (stall) begin
            n++;
            assert (n < wait_limit) else report_error($sformatf("stall stuck high in %s", name));
            @(negedge clk);
        end
    endtask

    // Counts falling edges from acceptance to the result pulse.
    task automatic wait_result(input string name, input bit mem_op, output int lat);
        bit seen;
        lat  = 0;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            lat++;
            seen = result.valid || result.trap;
            if (!seen && mem_op && !dbus_resp.ready) begin
                assert (stall) else report_error($sformatf("stall low while bus waits in %s", name));
            end
            assert (seen || lat < wait_limit)
                else report_error($sformatf("no result for %s", name));
        end
    endtask

    initial begin
        test_entry_t t;
        int          lat;
        bit          is_mem;
        void'($urandom(28368));
        rst          = 1'b1;
        req          = '0;
        preload_en   = 1'b0;
        probe_addr   = '0;
        preload_data = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!stall && !dbus_req.re && dbus_req.we == 4'b0000 && !result.valid &&
                !result.trap) else report_error("outputs not idle after reset");

        for (int i = 0; i < num_tests; i++) begin
            t      = tbl[i];
            is_mem = !t.exp_trap && (t.kind == kd_ld || t.kind == kd_st || t.kind == kd_amo);
            // Memory word is loaded on the same edge that accepts the request.
            @(posedge clk);
            preload_en   <= 1'b1;
            probe_addr   <= t.addr[31:2];
            preload_data <= t.init;
            req.valid    <= 1'b1;
            req.insn     <= make_insn(t.kind, t.funct);
            // Stores write no register.
            req.use_rd   <= t.kind != kd_st;
            req.rs1_val  <= t.addr;
            req.rs2_val  <= t.wdata;
            req.trap     <= t.kind == kd_trp;
            req.cause    <= t.exp_cause;
            wait_stall_low(t.name);
            @(posedge clk);
            preload_en <= 1'b0;
            req.valid  <= 1'b0;
            req.trap   <= 1'b0;
            wait_result(t.name, is_mem, lat);

            check_word(t.name, "valid", 32'(!t.exp_trap), 32'(result.valid));
            check_word(t.name, "trap", 32'(t.exp_trap), 32'(result.trap));
            check_word(t.name, "use_rd", 32'(t.kind != kd_st), 32'(result.use_rd));
            if (t.exp_trap) begin
                check_word(t.name, "cause", 32'(t.exp_cause), 32'(result.cause));
            end else if (t.kind != kd_st) begin
                check_word(t.name, "rd_val", t.exp_rd, result.rd_val);
            end
            check_word(t.name, "memory", t.exp_mem, peek_data);
            if (!is_mem) begin
                check_word(t.name, "latency", 32'd2, 32'(lat));
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== dv/dbus_model.sv ====
// Behavioral data memory for the memory stage testbench with a random ready delay.
`timescale 1ns/100ps

module dbus_model (
    input  logic                      clk,
    input  logic                      rst,
    input  mem_stage_pkg::dbus_req_t  dbus_req,
    output mem_stage_pkg::dbus_resp_t dbus_resp,
    input  logic                      preload_en,
    input  logic [29:0]               probe_addr,
    input  logic [31:0]               preload_data,
    output logic [31:0]               peek_data
);
    import mem_stage_pkg::*;

    logic [31:0] mem [16];
    logic [1:0]  delay;
    logic        active;

    assign active          = dbus_req.re || dbus_req.we != 4'b0000;
    assign dbus_resp.ready = active && delay == 2'd0;
    // Read data shows the word before any write in the same cycle.
    assign dbus_resp.rdata = mem[dbus_req.addr[3:0]];
    assign peek_data       = mem[probe_addr[3:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            delay <= 2'($urandom % 4);
            // Power-up contents follow the word index.
            for (int i = 0; i < 16; i++) begin
                mem[i] <= 32'h5a00_0000 | (i * 32'h0001_0101);
            end
        end else begin
            // A fresh delay of 0 to 3 cycles after each completed access.
            if (dbus_resp.ready) begin
                delay <= 2'($urandom % 4);
            end else if (active) begin
                delay <= delay - 2'd1;
            end
            if (preload_en) begin
                mem[probe_addr[3:0]] <= preload_data;
            end else if (dbus_resp.ready) begin
                for (int b = 0; b < 4; b++) begin
                    if (dbus_req.we[b]) begin
                        mem[dbus_req.addr[3:0]][8*b +: 8] <= dbus_req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== source/mem_stage.sv ====
// Memory stage top level joining decode, bus sequencer and result register.
`timescale 1ns/100ps

module mem_stage #(
    parameter bit has_amo = 1'b1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_stage_pkg::mem_req_t    req,
    input  mem_stage_pkg::dbus_resp_t  dbus_resp,
    output mem_stage_pkg::dbus_req_t   dbus_req,
    output mem_stage_pkg::mem_result_t result,
    output logic                       stall
);
    import mem_stage_pkg::*;

    mem_acc_t    acc;
    logic        done;
    logic [31:0] load_data;

    mem_op_decode #(
        .has_amo (has_amo)
    ) u_decode (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .stall (stall),
        .acc   (acc)
    );

    mem_access_seq #(
        .has_amo (has_amo)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .acc       (acc),
        .dbus_resp (dbus_resp),
        .dbus_req  (dbus_req),
        .stall     (stall),
        .done      (done),
        .load_data (load_data)
    );

    mem_result u_result (
        .clk       (clk),
        .rst       (rst),
        .acc       (acc),
        .done      (done),
        .load_data (load_data),
        .result    (result)
    );

endmodule

// ==== source/mem_result.sv ====
// Memory stage result register that picks the rd value and trap towards writeback.
`timescale 1ns/100ps

module mem_result (
    input  logic                       clk,
    input  logic                       rst,
    input  mem_stage_pkg::mem_acc_t    acc,
    input  logic                       done,
    input  logic [31:0]                load_data,
    output mem_stage_pkg::mem_result_t result
);
    import mem_stage_pkg::*;

    logic finish;

    // An entry ends with done, or at once when it does not touch memory.
    assign finish = acc.valid && (acc.op == op_none || done);

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
            result.trap  <= 1'b0;
        end else begin
            result.valid <= finish && !acc.trap;
            result.trap  <= finish && acc.trap;
            if (finish) begin
                result.use_rd <= acc.use_rd;
                result.cause  <= acc.cause;
                // Stores take load_data here, which writeback ignores.
                result.rd_val <= (acc.op == op_none) ? acc.rs1_val : load_data;
            end
        end
    end

endmodule

// ==== source/mem_access_seq.sv ====
// Data bus sequencer with byte lanes, load extraction and two-phase read-modify-write atomics.
`timescale 1ns/100ps

module mem_access_seq #(
    parameter bit has_amo = 1'b1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  mem_stage_pkg::mem_acc_t   acc,
    input  mem_stage_pkg::dbus_resp_t dbus_resp,
    output mem_stage_pkg::dbus_req_t  dbus_req,
    output logic                      stall,
    output logic                      done,
    output logic [31:0]               load_data
);
    import mem_stage_pkg::*;

    typedef enum logic [1:0] {
        ph_idle,
        ph_read,
        ph_write
    } amo_phase_e;

    amo_phase_e  phase;
    logic [31:0] old_q;
    logic [31:0] amo_wdata;
    logic [31:0] store_word;
    logic [31:0] lane_data;
    logic [31:0] lane;
    logic [3:0]  byte_en;
    logic        is_rmw;
    logic        rd_cycle;
    logic        wr_cycle;

    assign is_rmw = acc.op == op_amo_rmw;

    // Swap is a single write. The bus returns the prior word with ready.
    assign rd_cycle = acc.op == op_load || (is_rmw && phase != ph_write);
    assign wr_cycle = acc.op == op_store || acc.op == op_amo_swap ||
                      (is_rmw && phase == ph_write);

    generate
        if (has_amo) begin : g_amo
            amo_alu u_amo_alu (
                .rmw_funct (acc.amo_funct),
                .old_val   (old_q),
                .operand   (acc.wdata),
                .new_val   (amo_wdata)
            );
        end else begin : g_no_amo
            assign amo_wdata = acc.wdata;
        end
    endgenerate

    assign store_word = is_rmw ? amo_wdata : acc.wdata;

    // Lane enables and replicated store data.
    always_comb begin
        case (acc.size)
            size_byte: begin
                byte_en   = 4'b0001 << acc.addr[1:0];
                lane_data = {4{store_word[7:0]}};
            end
            size_half: begin
                byte_en   = 4'b0011 << {acc.addr[1], 1'b0};
                lane_data = {2{store_word[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                lane_data = store_word;
            end
        endcase
    end

    always_comb begin
        dbus_req.re    = rd_cycle;
        dbus_req.we    = wr_cycle ? byte_en : 4'b0000;
        dbus_req.addr  = acc.addr[31:2];
        dbus_req.wdata = lane_data;
    end

    assign done = dbus_resp.ready &&
                  (acc.op == op_load || acc.op == op_store || acc.op == op_amo_swap ||
                   (is_rmw && phase == ph_write));

    assign stall = acc.op != op_none && !done;

    // Atomic phase. The read may wait on ready in ph_read.
    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= ph_idle;
        end else begin
            case (phase)
                ph_idle, ph_read: begin
                    if (is_rmw) begin
                        phase <= dbus_resp.ready ? ph_write : ph_read;
                    end
                end
                ph_write: begin
                    if (dbus_resp.ready) begin
                        phase <= ph_idle;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    // Old memory word of the atomic.
    always_ff @(posedge clk) begin
        if (is_rmw && rd_cycle && dbus_resp.ready) begin
            old_q <= dbus_resp.rdata;
        end
    end

    assign lane = dbus_resp.rdata >> {acc.addr[1:0], 3'b000};

    always_comb begin
        case (acc.op)
            op_amo_rmw:  load_data = old_q;
            op_amo_swap: load_data = dbus_resp.rdata;
            default: begin
                case (acc.size)
                    size_byte: load_data = {{24{acc.sign & lane[7]}}, lane[7:0]};
                    size_half: load_data = {{16{acc.sign & lane[15]}}, lane[15:0]};
                    default:   load_data = dbus_resp.rdata;
                endcase
            end
        endcase
    end

    a_no_re_with_we: assert property (@(posedge clk) disable iff (rst)
        !(dbus_req.re && dbus_req.we != 4'b0000));

    a_load_no_we: assert property (@(posedge clk) disable iff (rst)
        acc.op == op_load |-> dbus_req.we == 4'b0000);

endmodule

// ==== source/mem_op_decode.sv ====
// Memory stage decode with the execute barrier register, op classification and alignment trap.
`timescale 1ns/100ps

module mem_op_decode #(
    parameter bit has_amo = 1'b1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  mem_stage_pkg::mem_req_t req,
    input  logic                    stall,
    output mem_stage_pkg::mem_acc_t acc
);
    import mem_stage_pkg::*;

    mem_req_t  r_req;
    rv_insn_u  insn;
    mem_op_e   op_class;
    acc_size_e size;
    logic      amo_bad;
    logic      illegal;
    logic      misalign;

    // Barrier register. Held while the sequencer is busy.
    always_ff @(posedge clk) begin
        if (rst) begin
            r_req.valid <= 1'b0;
            r_req.trap  <= 1'b0;
        end else if (!stall) begin
            r_req <= req;
        end
    end

    assign insn = r_req.insn;

    always_comb begin
        case (insn.ls.opcode[6:2])
            op_load_c:  op_class = op_load;
            op_store_c: op_class = op_store;
            op_amo_c:   op_class = (insn.amo.funct5[1:0] == 2'b01) ? op_amo_swap : op_amo_rmw;
            default:    op_class = op_none;
        endcase
        if (!r_req.valid) begin
            op_class = op_none;
        end
    end

    // Atomics are word only.
    assign size = (op_class == op_amo_rmw || op_class == op_amo_swap) ?
                  size_word : acc_size_e'(insn.ls.funct3[1:0]);

    // LR and SC are not supported and decode as illegal.
    assign amo_bad = !has_amo || insn.amo.funct5[1] || insn.amo.funct3 != 3'b010;

    assign illegal = ((op_class == op_load || op_class == op_store) && size == size_bad) ||
                     ((op_class == op_amo_rmw || op_class == op_amo_swap) && amo_bad);

    always_comb begin
        case (size)
            size_half: misalign = r_req.rs1_val[0];
            size_word: misalign = r_req.rs1_val[1:0] != 2'b00;
            default:   misalign = 1'b0;
        endcase
    end

    always_comb begin
        acc.valid     = r_req.valid || r_req.trap;
        acc.size      = size;
        acc.sign      = !insn.ls.funct3[2];
        acc.amo_funct = insn.amo.funct5[4:2];
        acc.addr      = r_req.rs1_val;
        acc.wdata     = r_req.rs2_val;
        acc.use_rd    = r_req.use_rd;
        acc.rs1_val   = r_req.rs1_val;
        acc.trap      = 1'b0;
        acc.cause     = r_req.cause;
        if (r_req.trap) begin
            acc.trap  = 1'b1;
        end else if (illegal) begin
            acc.trap  = 1'b1;
            acc.cause = cause_illegal_c;
        end else if (op_class != op_none && misalign) begin
            acc.trap  = 1'b1;
            acc.cause = (op_class == op_load) ? cause_lmisalign_c : cause_smisalign_c;
        end
        // Trapped ops never reach the bus.
        acc.op = acc.trap ? op_none : op_class;
    end

    // A pending request from upstream is held until a stall-free edge takes it.
    a_req_held_under_stall: assert property (@(posedge clk) disable iff (rst)
        stall && req.valid |=> $stable(req));

endmodule

// ==== source/amo_alu.sv ====
// Atomic write data calculator for add, bitwise and min/max read-modify-write ops.
`timescale 1ns/100ps

module amo_alu (
    input  logic [2:0]  rmw_funct,
    input  logic [31:0] old_val,
    input  logic [31:0] operand,
    output logic [31:0] new_val
);
    logic [31:0] sign_flip;
    logic [31:0] lhs;
    logic [31:0] rhs;
    logic [32:0] diff;
    logic        old_ge;

    // Signed compare when funct bit 1 is low.
    assign sign_flip = {~rmw_funct[1], 31'b0};
    assign lhs       = old_val ^ sign_flip;
    assign rhs       = operand ^ sign_flip;

    // Carry out is set when old >= operand.
    assign diff   = {1'b0, lhs} + {1'b0, ~rhs} + 33'd1;
    assign old_ge = diff[32];

    always_comb begin
        case (rmw_funct)
            3'b000: new_val = old_val + operand;
            3'b001: new_val = old_val ^ operand;
            3'b010: new_val = old_val | operand;
            3'b011: new_val = old_val & operand;
            3'b100: new_val = old_ge ? operand : old_val;
            3'b101: new_val = old_ge ? old_val : operand;
            3'b110: new_val = old_ge ? operand : old_val;
            default: new_val = old_ge ? old_val : operand;
        endcase
    end

endmodule

// ==== source/mem_stage_pkg.sv ====
// Memory stage package with instruction views, access classes, bus records and trap causes.
package mem_stage_pkg;

    // Load and store view of an instruction word.
    typedef struct packed {
        logic [11:0] upper;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_ls_fields_t;

    // Atomic view of an instruction word.
    typedef struct packed {
        logic [4:0] funct5;
        logic       aq;
        logic       rl;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_amo_fields_t;

    // One instruction word, read through either view.
    typedef union packed {
        rv_ls_fields_t  ls;
        rv_amo_fields_t amo;
    } rv_insn_u;

    typedef enum logic [2:0] {
        op_none,
        op_load,
        op_store,
        op_amo_rmw,
        op_amo_swap
    } mem_op_e;

    // Encoded as funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word,
        size_bad
    } acc_size_e;

    // Request from execute.
    typedef struct packed {
        logic        valid;
        rv_insn_u    insn;
        logic        use_rd;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic        trap;
        logic [3:0]  cause;
    } mem_req_t;

    // Decoded access. Valid marks an entry, memory op or not.
    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        acc_size_e   size;
        logic        sign;
        logic [2:0]  amo_funct;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        use_rd;
        logic [31:0] rs1_val;
        logic        trap;
        logic [3:0]  cause;
    } mem_acc_t;

    typedef struct packed {
        logic        re;
        logic [3:0]  we;
        logic [29:0] addr;
        logic [31:0] wdata;
    } dbus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } dbus_resp_t;

    typedef struct packed {
        logic        valid;
        logic        use_rd;
        logic [31:0] rd_val;
        logic        trap;
        logic [3:0]  cause;
    } mem_result_t;

    // Major opcodes, insn[6:2].
    localparam logic [4:0] op_load_c  = 5'b00000;
    localparam logic [4:0] op_store_c = 5'b01000;
    localparam logic [4:0] op_amo_c   = 5'b01011;

    localparam logic [3:0] cause_illegal_c   = 4'd2;
    localparam logic [3:0] cause_lmisalign_c = 4'd4;
    localparam logic [3:0] cause_smisalign_c = 4'd6;

endpackage
